// ==== source/mips_pkg.sv ====
package mips_pkg;

  typedef logic [31:0] word_t;     // data and instruction word
  typedef logic [4:0]  reg_idx_t;  // register index
  typedef logic [5:0]  opcode_t;   // primary opcode, bits 31:26
  typedef logic [5:0]  funct_t;    // r-type function field, bits 5:0
  typedef logic [5:0]  aluop_t;    // {imm op, class}
  typedef logic [1:0]  loadsig_t;  // load width select

  typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, NOR, SLT, LUI} alu_op_e;
  typedef enum logic [1:0] {NONE, REG, MEM, OVF} ret_kind_e;

  // primary opcodes
  localparam opcode_t OP_RTYPE = 6'b000000;
  localparam opcode_t OP_ADDI  = 6'b001000;
  localparam opcode_t OP_ADDIU = 6'b001001;
  localparam opcode_t OP_SLTI  = 6'b001010;
  localparam opcode_t OP_ANDI  = 6'b001100;
  localparam opcode_t OP_ORI   = 6'b001101;
  localparam opcode_t OP_XORI  = 6'b001110;
  localparam opcode_t OP_LUI   = 6'b001111;
  localparam opcode_t OP_LW    = 6'b100011;
  localparam opcode_t OP_LBU   = 6'b100100;
  localparam opcode_t OP_LHU   = 6'b100101;
  localparam opcode_t OP_SW    = 6'b101011;

  // r-type functs
  localparam funct_t FN_ADD  = 6'b100000;
  localparam funct_t FN_ADDU = 6'b100001;
  localparam funct_t FN_SUB  = 6'b100010;
  localparam funct_t FN_SUBU = 6'b100011;
  localparam funct_t FN_AND  = 6'b100100;
  localparam funct_t FN_OR   = 6'b100101;
  localparam funct_t FN_XOR  = 6'b100110;
  localparam funct_t FN_NOR  = 6'b100111;
  localparam funct_t FN_SLT  = 6'b101010;

  // aluop class, low two bits
  localparam logic [1:0] CLS_ADDR = 2'b00;  // lw/sw address add
  localparam logic [1:0] CLS_R    = 2'b10;  // use funct
  localparam logic [1:0] CLS_IMM  = 2'b11;  // use upper aluop bits

  // aluop immediate operation, upper four bits
  localparam logic [3:0] IMM_ADD = 4'b0000;
  localparam logic [3:0] IMM_AND = 4'b0001;
  localparam logic [3:0] IMM_OR  = 4'b0010;
  localparam logic [3:0] IMM_XOR = 4'b0011;
  localparam logic [3:0] IMM_SLT = 4'b0110;
  localparam logic [3:0] IMM_LUI = 4'b0111;

  localparam loadsig_t LD_WORD = 2'b00;
  localparam loadsig_t LD_HALF = 2'b01;  // zero extended
  localparam loadsig_t LD_BYTE = 2'b10;  // zero extended

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

  // packed decoded operation, bit offsets from lsb
  localparam int OPB_FUNCT    = 0;   // 6 bits
  localparam int OPB_IMM      = 6;   // 32 bits, already extended
  localparam int OPB_DST      = 38;  // 5 bits, regdst applied
  localparam int OPB_RT       = 43;
  localparam int OPB_RS       = 48;
  localparam int OPB_LOADSIG  = 53;  // 2 bits
  localparam int OPB_ALUOP    = 55;  // 6 bits
  localparam int OPB_IFSIGN   = 61;
  localparam int OPB_REGWRITE = 62;
  localparam int OPB_ALUSRC   = 63;
  localparam int OPB_MEMWRITE = 64;
  localparam int OPB_MEMTOREG = 65;
  localparam int OPB_MEMREAD  = 66;
  localparam int OP_W         = 67;

endpackage

// ==== source/d_control.sv ====
`timescale 1ns/1ps
module d_control
  import mips_pkg::*;
(
  input  opcode_t  i_con_instru,
  output logic     o_con_regdst,   // 1: dest is rd (15:11), 0: rt (20:16)
  output logic     o_con_memread,
  output logic     o_con_memtoreg, // writeback from memory instead of alu
  output logic     o_con_memwrite,
  output logic     o_con_alusrc,   // 1: second operand is the immediate
  output logic     o_con_regwrite,
  output logic     o_con_ifsign,   // trapping signed immediate add
  output aluop_t   o_con_aluop,
  output loadsig_t o_con_loadsig
);

  always_comb begin
    // defaults, unsupported opcodes stay all zero
    o_con_regdst   = 1'b0;
    o_con_memread  = 1'b0;
    o_con_memtoreg = 1'b0;
    o_con_memwrite = 1'b0;
    o_con_alusrc   = 1'b0;
    o_con_regwrite = 1'b0;
    o_con_ifsign   = 1'b0;
    o_con_aluop    = '0;
    o_con_loadsig  = LD_WORD;
    casez (i_con_instru)
      OP_RTYPE: begin
        o_con_regdst   = 1'b1;
        o_con_regwrite = 1'b1;
        o_con_aluop    = {IMM_ADD, CLS_R};  // funct decides
      end
      OP_ADDI: begin
        o_con_regwrite = 1'b1;
        o_con_alusrc   = 1'b1;
        o_con_ifsign   = 1'b1;              // traps on overflow
        o_con_aluop    = {IMM_ADD, CLS_IMM};
      end
      OP_ADDIU: begin
        o_con_regwrite = 1'b1;
        o_con_alusrc   = 1'b1;
        o_con_aluop    = {IMM_ADD, CLS_IMM};
      end
      OP_ANDI: begin
        o_con_regwrite = 1'b1;
        o_con_alusrc   = 1'b1;
        o_con_aluop    = {IMM_AND, CLS_IMM};
      end
      OP_ORI: begin
        o_con_regwrite = 1'b1;
        o_con_alusrc   = 1'b1;
        o_con_aluop    = {IMM_OR, CLS_IMM};
      end
      OP_XORI: begin
        o_con_regwrite = 1'b1;
        o_con_alusrc   = 1'b1;
        o_con_aluop    = {IMM_XOR, CLS_IMM};
      end
      OP_SLTI: begin
        o_con_regwrite = 1'b1;
        o_con_alusrc   = 1'b1;
        o_con_ifsign   = 1'b0;              // signed compare, never traps
        o_con_aluop    = {IMM_SLT, CLS_IMM};
      end
      OP_LUI: begin
        o_con_regwrite = 1'b1;
        o_con_alusrc   = 1'b1;
        o_con_aluop    = {IMM_LUI, CLS_IMM};
      end
      OP_LW, OP_LHU, OP_LBU: begin
        o_con_regwrite = 1'b1;
        o_con_alusrc   = 1'b1;
        o_con_memread  = 1'b1;
        o_con_memtoreg = 1'b1;
        o_con_aluop    = {IMM_ADD, CLS_ADDR};
        if (i_con_instru == OP_LHU)
          o_con_loadsig = LD_HALF;
        else if (i_con_instru == OP_LBU)
          o_con_loadsig = LD_BYTE;
      end
      OP_SW: begin
        o_con_alusrc   = 1'b1;
        o_con_memwrite = 1'b1;
        o_con_aluop    = {IMM_ADD, CLS_ADDR};
      end
      default: ;
    endcase
  end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps
module alu
  import mips_pkg::*;
(
  input  aluop_t i_aluop,
  input  funct_t i_funct,
  input  word_t  i_a,
  input  word_t  i_b,
  output word_t  o_result,
  output logic   o_ovf     // r-type add/sub signed overflow only
);

  alu_op_e op;
  word_t   sum;
  word_t   diff;

  assign sum  = i_a + i_b;
  assign diff = i_a - i_b;

  always_comb begin
    op = ADD;                        // address add and unknown functs
    if (i_aluop[1:0] == CLS_R) begin
      case (i_funct)
        FN_ADD, FN_ADDU: op = ADD;
        FN_SUB, FN_SUBU: op = SUB;
        FN_AND:          op = AND;
        FN_OR:           op = OR;
        FN_XOR:          op = XOR;
        FN_NOR:          op = NOR;
        FN_SLT:          op = SLT;
        default:         op = ADD;
      endcase
    end else if (i_aluop[1:0] == CLS_IMM) begin
      case (i_aluop[5:2])
        IMM_AND: op = AND;
        IMM_OR:  op = OR;
        IMM_XOR: op = XOR;
        IMM_SLT: op = SLT;
        IMM_LUI: op = LUI;
        default: op = ADD;
      endcase
    end
  end

  always_comb begin
    case (op)
      SUB:     o_result = diff;
      AND:     o_result = i_a & i_b;
      OR:      o_result = i_a | i_b;
      XOR:     o_result = i_a ^ i_b;
      NOR:     o_result = ~(i_a | i_b);
      SLT:     o_result = {31'b0, $signed(i_a) < $signed(i_b)};
      LUI:     o_result = {i_b[15:0], 16'b0};
      default: o_result = sum;
    endcase
  end

  // same-sign operands giving a result of the other sign
  always_comb begin
    o_ovf = 1'b0;
    if (i_aluop[1:0] == CLS_R && i_funct == FN_ADD)
      o_ovf = (i_a[31] == i_b[31]) && (sum[31] != i_a[31]);
    else if (i_aluop[1:0] == CLS_R && i_funct == FN_SUB)
      o_ovf = (i_a[31] != i_b[31]) && (diff[31] != i_a[31]);
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
module reg_file
  import mips_pkg::*;
(
  input  logic     clk,
  input  logic     i_arst_n,
  input  reg_idx_t i_rs,
  input  reg_idx_t i_rt,
  output word_t    o_rs_data,
  output word_t    o_rt_data,
  input  logic     i_we,
  input  reg_idx_t i_wa,
  input  word_t    i_wd
);

  word_t regs [32];

  // combinational reads, r0 never written so it reads zero
  assign o_rs_data = regs[i_rs];
  assign o_rt_data = regs[i_rt];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (i_we && i_wa != '0) begin
      regs[i_wa] <= i_wd;
    end
  end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
module decode_stage
  import mips_pkg::*;
(
  input  logic            clk,
  input  logic            i_arst_n,
  input  logic            i_ins_req,
  input  word_t           i_ins_word,
  output logic            o_ins_ack,
  output logic            o_push,     // one cycle, with o_op
  output logic [OP_W-1:0] o_op,
  input  logic            i_full
);

  typedef enum logic {IDLE, ACKED} state_e;

  state_e          state;
  opcode_t         opcode;
  reg_idx_t        rs, rt, rd;
  funct_t          funct;
  word_t           imm;
  logic            zext;
  logic            regdst, memread, memtoreg, memwrite, alusrc, regwrite, ifsign;
  aluop_t          aluop;
  loadsig_t        loadsig;
  logic [OP_W-1:0] op_d;
  logic            take;

  assign opcode = i_ins_word[31:26];
  assign rs     = i_ins_word[25:21];
  assign rt     = i_ins_word[20:16];
  assign rd     = i_ins_word[15:11];
  assign funct  = i_ins_word[5:0];

  d_control u_ctrl (
    .i_con_instru   (opcode),
    .o_con_regdst   (regdst),
    .o_con_memread  (memread),
    .o_con_memtoreg (memtoreg),
    .o_con_memwrite (memwrite),
    .o_con_alusrc   (alusrc),
    .o_con_regwrite (regwrite),
    .o_con_ifsign   (ifsign),
    .o_con_aluop    (aluop),
    .o_con_loadsig  (loadsig)
  );

  // logical immediates zero extend, everything else sign extends
  assign zext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
  assign imm  = zext ? {16'b0, i_ins_word[15:0]} : {{16{i_ins_word[15]}}, i_ins_word[15:0]};

  always_comb begin
    op_d = '0;
    op_d[OPB_FUNCT +: 6]   = funct;
    op_d[OPB_IMM +: 32]    = imm;
    op_d[OPB_DST +: 5]     = regdst ? rd : rt;  // exec never sees regdst
    op_d[OPB_RT +: 5]      = rt;
    op_d[OPB_RS +: 5]      = rs;
    op_d[OPB_LOADSIG +: 2] = loadsig;
    op_d[OPB_ALUOP +: 6]   = aluop;
    op_d[OPB_IFSIGN]       = ifsign;
    op_d[OPB_REGWRITE]     = regwrite;
    op_d[OPB_ALUSRC]       = alusrc;
    op_d[OPB_MEMWRITE]     = memwrite;
    op_d[OPB_MEMTOREG]     = memtoreg;
    op_d[OPB_MEMREAD]      = memread;
  end

  assign take = (state == IDLE) && i_ins_req && !i_full;  // full holds off the ack

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= IDLE;
      o_ins_ack <= 1'b0;
      o_push    <= 1'b0;
    end else begin
      o_push <= take;
      case (state)
        IDLE: if (take) begin
          o_ins_ack <= 1'b1;
          state     <= ACKED;
        end
        ACKED: if (!i_ins_req) begin  // release phase
          o_ins_ack <= 1'b0;
          state     <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take)
      o_op <= op_d;
  end

endmodule

// ==== source/op_fifo.sv ====
`timescale 1ns/1ps
module op_fifo
  import mips_pkg::*;
(
  input  logic            clk,
  input  logic            i_arst_n,
  input  logic            i_push,
  input  logic [OP_W-1:0] i_data,
  output logic            o_full,
  input  logic            i_pop,
  output logic            o_empty,
  output logic [OP_W-1:0] o_head   // show-ahead, valid while not empty
);

  logic [OP_W-1:0]       mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  assign o_full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign o_empty = (count == '0);
  assign o_head  = mem[rd_ptr];

  assign do_push = i_push && !o_full;   // push into full is dropped
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= i_data;
  end

endmodule

// ==== source/exec_stage.sv ====
`timescale 1ns/1ps
module exec_stage
  import mips_pkg::*;
(
  input  logic            clk,
  input  logic            i_arst_n,
  input  logic            i_empty,
  input  logic [OP_W-1:0] i_head,
  output logic            o_pop,
  output logic            o_ret_req,
  output ret_kind_e       o_ret_kind,
  output reg_idx_t        o_ret_idx,
  output word_t           o_ret_data,
  input  logic            i_ret_ack
);

  typedef enum logic [1:0] {IDLE, REPORT, WAIT_REL} state_e;

  state_e    state;
  reg_idx_t  h_rs, h_rt, h_dst;
  word_t     h_imm;
  logic      h_memread, h_memtoreg, h_memwrite, h_alusrc, h_regwrite, h_ifsign;
  loadsig_t  h_loadsig;
  word_t     rs_data, rt_data, alu_b, alu_res;
  logic      alu_ovf, ovf;
  word_t     mem_word, ld_ext;
  ret_kind_e kind_d, kind_q;
  word_t     alu_q, ld_q, st_q, wb_q;
  reg_idx_t  dst_q;
  logic      memtoreg_q;
  logic      take, commit;
  word_t     dmem [DMEM_WORDS];

  // head entry fields
  assign h_rs       = i_head[OPB_RS +: 5];
  assign h_rt       = i_head[OPB_RT +: 5];
  assign h_dst      = i_head[OPB_DST +: 5];
  assign h_imm      = i_head[OPB_IMM +: 32];
  assign h_loadsig  = i_head[OPB_LOADSIG +: 2];
  assign h_memread  = i_head[OPB_MEMREAD];
  assign h_memtoreg = i_head[OPB_MEMTOREG];
  assign h_memwrite = i_head[OPB_MEMWRITE];
  assign h_alusrc   = i_head[OPB_ALUSRC];
  assign h_regwrite = i_head[OPB_REGWRITE];
  assign h_ifsign   = i_head[OPB_IFSIGN];

  assign take   = (state == IDLE) && o_pop;         // head is being consumed
  assign commit = (state == REPORT) && i_ret_ack;   // writes land on ack

  reg_file u_rf (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_rs      (h_rs),
    .i_rt      (h_rt),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data),
    .i_we      (commit && kind_q == REG),
    .i_wa      (dst_q),
    .i_wd      (wb_q)
  );

  assign alu_b = h_alusrc ? h_imm : rt_data;

  alu u_alu (
    .i_aluop  (i_head[OPB_ALUOP +: 6]),
    .i_funct  (i_head[OPB_FUNCT +: 6]),
    .i_a      (rs_data),
    .i_b      (alu_b),
    .o_result (alu_res),
    .o_ovf    (alu_ovf)
  );

  // addi trap computed here from the same sum
  assign ovf = alu_ovf ||
               (h_ifsign && (rs_data[31] == alu_b[31]) && (alu_res[31] != rs_data[31]));

  assign mem_word = dmem[alu_res[DMEM_IDX_W+1:2]];  // word index from addr 9:2

  always_comb begin
    case (h_loadsig)
      LD_HALF: ld_ext = {16'b0, alu_res[1] ? mem_word[31:16] : mem_word[15:0]};
      LD_BYTE: ld_ext = {24'b0, mem_word[8*alu_res[1:0] +: 8]};  // little endian lane
      default: ld_ext = mem_word;
    endcase
  end

  always_comb begin
    if (ovf)
      kind_d = OVF;        // trap wins, nothing written
    else if (h_regwrite)
      kind_d = REG;
    else if (h_memwrite)
      kind_d = MEM;
    else
      kind_d = NONE;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= IDLE;
      o_pop     <= 1'b0;
      o_ret_req <= 1'b0;
      kind_q    <= NONE;
    end else begin
      case (state)
        IDLE: if (o_pop) begin
          o_pop     <= 1'b0;
          kind_q    <= kind_d;
          o_ret_req <= 1'b1;
          state     <= REPORT;
        end else if (!i_empty) begin
          o_pop <= 1'b1;
        end
        REPORT: if (i_ret_ack) begin
          o_ret_req <= 1'b0;
          state     <= WAIT_REL;
        end
        WAIT_REL: if (!i_ret_ack)
          state <= IDLE;   // next op may be popped from here
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      alu_q      <= alu_res;
      st_q       <= rt_data;     // store data
      dst_q      <= h_dst;
      memtoreg_q <= h_memtoreg;
      if (h_memread)
        ld_q <= ld_ext;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i] <= '0;
    end else if (commit && kind_q == MEM) begin
      dmem[alu_q[DMEM_IDX_W+1:2]] <= st_q;
    end
  end

  assign wb_q       = memtoreg_q ? ld_q : alu_q;
  assign o_ret_kind = kind_q;
  assign o_ret_idx  = (kind_q == REG) ? dst_q : (kind_q == MEM) ? alu_q[6:2] : '0;
  assign o_ret_data = (kind_q == REG) ? wb_q : (kind_q == MEM) ? st_q : '0;

endmodule

// ==== source/mips_exec_top.sv ====
`timescale 1ns/1ps
module mips_exec_top
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      i_arst_n,
  input  logic      i_ins_req,
  input  word_t     i_ins_word,
  output logic      o_ins_ack,
  output logic      o_ret_req,
  output ret_kind_e o_ret_kind,
  output reg_idx_t  o_ret_idx,
  output word_t     o_ret_data,
  input  logic      i_ret_ack
);

  logic            push, full, pop, empty;
  logic [OP_W-1:0] op;    // decode to fifo
  logic [OP_W-1:0] head;  // fifo to exec

  decode_stage u_decode (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_ins_req  (i_ins_req),
    .i_ins_word (i_ins_word),
    .o_ins_ack  (o_ins_ack),
    .o_push     (push),
    .o_op       (op),
    .i_full     (full)
  );

  op_fifo u_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (push),
    .i_data   (op),
    .o_full   (full),
    .i_pop    (pop),
    .o_empty  (empty),
    .o_head   (head)
  );

  exec_stage u_exec (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_empty    (empty),
    .i_head     (head),
    .o_pop      (pop),
    .o_ret_req  (o_ret_req),
    .o_ret_kind (o_ret_kind),
    .o_ret_idx  (o_ret_idx),
    .o_ret_data (o_ret_data),
    .i_ret_ack  (i_ret_ack)
  );

endmodule

// ==== tb/tb_tests.svh ====
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

function automatic word_t enc_r(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
  return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic word_t rand_word();
  return $random(seed);
endfunction

// lui then ori, two retires
task automatic load_reg(reg_idx_t idx, word_t v);
  send_ins(enc_i(OP_LUI, 5'd0, idx, v[31:16]));
  send_ins(enc_i(OP_ORI, idx, idx, v[15:0]));
endtask

task automatic imm_alu_ops();
  word_t       r;
  logic [15:0] imm;
  cur_test = "imm_alu";
  for (int i = 0; i < 6; i++) begin
    load_reg(5'd1, rand_word());
    r   = rand_word();
    imm = r[15:0];
    if (i % 2 == 0)
      imm[15] = 1'b1;               // exercise zero vs sign extension
    send_ins(enc_i(OP_ADDIU, 5'd1, 5'd2, imm));
    send_ins(enc_i(OP_ANDI, 5'd1, 5'd3, imm));
    send_ins(enc_i(OP_ORI, 5'd1, 5'd4, imm));
    send_ins(enc_i(OP_XORI, 5'd1, 5'd5, imm));
    send_ins(enc_i(OP_SLTI, 5'd1, 5'd6, imm));
    send_ins(enc_i(OP_LUI, 5'd0, 5'd7, imm));
  end
  drain();
endtask

task automatic rtype_ops();
  funct_t fns [9];
  cur_test = "r_type";
  fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
  for (int p = 0; p < 3; p++) begin
    load_reg(5'd8, rand_word());
    load_reg(5'd9, rand_word());
    for (int k = 0; k < 9; k++)
      send_ins(enc_r(fns[k], 5'd8, 5'd9, 5'(10 + k)));
  end
  send_ins(enc_r(FN_ADDU, 5'd8, 5'd9, 5'd0));  // r0 target still reports REG
  send_ins(enc_r(FN_OR, 5'd0, 5'd0, 5'd19));   // r0 reads back zero
  send_ins(enc_r(FN_ADDU, 5'd0, 5'd8, 5'd19));
  drain();
endtask

task automatic overflow_trap();
  cur_test = "overflow";
  load_reg(5'd12, 32'h7fff_ffff);
  load_reg(5'd13, 32'h0000_1234);
  load_reg(5'd15, 32'h8000_0000);
  send_ins(enc_i(OP_ADDI, 5'd12, 5'd13, 16'h0001));  // positive wrap
  send_ins(enc_r(FN_OR, 5'd13, 5'd0, 5'd14));        // r13 untouched
  send_ins(enc_r(FN_ADD, 5'd12, 5'd12, 5'd13));
  send_ins(enc_r(FN_ADD, 5'd15, 5'd15, 5'd13));      // negative wrap
  send_ins(enc_r(FN_SUB, 5'd15, 5'd12, 5'd13));
  send_ins(enc_r(FN_OR, 5'd13, 5'd0, 5'd14));
  send_ins(enc_i(OP_ADDIU, 5'd12, 5'd13, 16'h0001)); // unsigned form never traps
  drain();
endtask

task automatic memory_access();
  cur_test = "memory";
  load_reg(5'd16, 32'h0000_0040);
  for (int k = 0; k < 3; k++) begin
    load_reg(5'd17, rand_word());
    send_ins(enc_i(OP_SW, 5'd16, 5'd17, 16'(4 * k)));
    send_ins(enc_i(OP_LW, 5'd16, 5'd18, 16'(4 * k)));
    for (int b = 0; b < 4; b++)
      send_ins(enc_i(OP_LBU, 5'd16, 5'd19, 16'(4 * k + b)));
    for (int h = 0; h < 2; h++)
      send_ins(enc_i(OP_LHU, 5'd16, 5'd20, 16'(4 * k + 2 * h)));
  end
  drain();
endtask

task automatic back_pressure();
  cur_test = "back_pressure";
  hold_ret = 1'b1;
  // dependent chain, any reordering shows up in the values
  for (int k = 0; k < 5; k++)
    send_ins(enc_i(OP_ADDIU, 5'd21, 5'd21, 16'(k + 1)));
  raise_ins(enc_i(OP_ADDIU, 5'd21, 5'd21, 16'd6));
  for (int n = 0; n < 12; n++) begin
    tick();
    compare_field("ins_ack while full", 32'd0, 32'(o_ins_ack));
  end
  hold_ret = 1'b0;
  finish_ins();
  drain();
endtask

task automatic unsupported_opcode();
  cur_test = "unsupported";
  load_reg(5'd22, rand_word());
  send_ins(enc_i(6'b000100, 5'd22, 5'd22, 16'h0010));  // beq
  send_ins(enc_i(6'b000101, 5'd22, 5'd22, 16'hfff0));  // bne
  send_ins(enc_r(FN_OR, 5'd22, 5'd0, 5'd23));
  drain();
endtask

`endif

// ==== tb/tb_mips_exec.sv ====
`timescale 1ns/1ps
module tb_mips_exec
  import mips_pkg::*;
;

  localparam int TMO       = 200;   // cycles allowed for one handshake phase
  localparam int DRAIN_TMO = 4000;  // cycles allowed to empty the expect queue

  logic      clk;
  logic      i_arst_n;
  logic      i_ins_req;
  word_t     i_ins_word;
  logic      o_ins_ack;
  logic      o_ret_req;
  ret_kind_e o_ret_kind;
  reg_idx_t  o_ret_idx;
  word_t     o_ret_data;
  logic      i_ret_ack;

  integer    seed;
  int        check_errs;
  int        timeouts;
  string     cur_test;
  logic      hold_ret;               // monitor leaves retires unacked while set

  // reference model state in program order
  word_t     model_regs [32];
  word_t     model_mem [DMEM_WORDS];
  ret_kind_e exp_kind [$];
  reg_idx_t  exp_idx [$];
  word_t     exp_data [$];

  mips_exec_top i_dut (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_ins_req  (i_ins_req),
    .i_ins_word (i_ins_word),
    .o_ins_ack  (o_ins_ack),
    .o_ret_req  (o_ret_req),
    .o_ret_kind (o_ret_kind),
    .o_ret_idx  (o_ret_idx),
    .o_ret_data (o_ret_data),
    .i_ret_ack  (i_ret_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // drive and sample 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_field(string field, word_t exp, word_t act);
    assert (exp === act) else begin
      check_errs++;
      $display("FAILED %s %s expected %h actual %h", cur_test, field, exp, act);
    end
  endtask

  task automatic report_timeout(string what);
    timeouts++;
    $display("timeout in %s: %s", cur_test, what);
  endtask

  function automatic longint sx(word_t v);
    return longint'($signed(v));
  endfunction

  function automatic logic overflows(longint s);
    return (s > 64'sd2147483647) || (s < -64'sd2147483648);
  endfunction

  // instruction semantics and the retire report the core must give
  task automatic predict(word_t w);
    opcode_t   op;
    reg_idx_t  rs, rt, rd, dst;
    funct_t    fn;
    word_t     a, b, se, ze, r, addr, mw;
    ret_kind_e k;
    op   = w[31:26];
    rs   = w[25:21];
    rt   = w[20:16];
    rd   = w[15:11];
    fn   = w[5:0];
    a    = model_regs[rs];
    b    = model_regs[rt];
    se   = {{16{w[15]}}, w[15:0]};
    ze   = {16'h0, w[15:0]};
    addr = a + se;                    // load/store effective address
    mw   = model_mem[addr[9:2]];
    k    = REG;
    dst  = rt;
    r    = '0;
    case (op)
      OP_RTYPE: begin
        dst = rd;
        case (fn)
          FN_ADD: begin
            r = a + b;
            if (overflows(sx(a) + sx(b))) k = OVF;
          end
          FN_ADDU: r = a + b;
          FN_SUB: begin
            r = a - b;
            if (overflows(sx(a) - sx(b))) k = OVF;
          end
          FN_SUBU: r = a - b;
          FN_AND:  r = a & b;
          FN_OR:   r = a | b;
          FN_XOR:  r = a ^ b;
          FN_NOR:  r = ~(a | b);
          FN_SLT:  r = (sx(a) < sx(b)) ? 32'd1 : 32'd0;
          default: k = NONE;          // functs outside the subset are never issued
        endcase
      end
      OP_ADDI: begin
        r = a + se;
        if (overflows(sx(a) + sx(se))) k = OVF;
      end
      OP_ADDIU: r = a + se;
      OP_SLTI:  r = (sx(a) < sx(se)) ? 32'd1 : 32'd0;
      OP_ANDI:  r = a & ze;
      OP_ORI:   r = a | ze;
      OP_XORI:  r = a ^ ze;
      OP_LUI:   r = {w[15:0], 16'h0};
      OP_LW:    r = mw;
      OP_LHU:   r = (mw >> (16 * addr[1])) & 32'hffff;   // halfword lane by address bit 1
      OP_LBU:   r = (mw >> (8 * addr[1:0])) & 32'hff;  // byte lane by low address bits
      OP_SW: begin
        k = MEM;
        model_mem[addr[9:2]] = b;
      end
      default: k = NONE;
    endcase
    if (k == REG && dst != 5'd0)
      model_regs[dst] = r;
    exp_kind.push_back(k);
    exp_idx.push_back((k == REG) ? dst : (k == MEM) ? addr[6:2] : 5'd0);
    exp_data.push_back((k == REG) ? r : (k == MEM) ? b : 32'h0);
  endtask

  // word and req up for the first half of the input handshake
  task automatic raise_ins(word_t w);
    predict(w);
    i_ins_word = w;
    i_ins_req  = 1'b1;
  endtask

  task automatic finish_ins();
    int n;
    n = 0;
    while (!o_ins_ack && n < TMO) begin
      tick();
      n++;
    end
    if (!o_ins_ack) report_timeout("instruction was never acknowledged");
    i_ins_req = 1'b0;
    n = 0;
    while (o_ins_ack && n < TMO) begin
      tick();
      n++;
    end
    if (o_ins_ack) report_timeout("instruction ack never dropped");
  endtask

  task automatic send_ins(word_t w);
    raise_ins(w);
    finish_ins();
  endtask

  // wait until every issued instruction has retired
  task automatic drain();
    int n;
    n = 0;
    while ((exp_kind.size() != 0 || o_ret_req) && n < DRAIN_TMO) begin
      tick();
      n++;
    end
    if (exp_kind.size() != 0 || o_ret_req) begin
      report_timeout("retire reports still missing");
      exp_kind.delete();
      exp_idx.delete();
      exp_data.delete();
    end
  endtask

  task automatic take_retire();
    ret_kind_e k;
    reg_idx_t  idx;
    word_t     d;
    int        n;
    assert (exp_kind.size() != 0) else begin
      check_errs++;
      $display("retire report arrived with no instruction outstanding in %s", cur_test);
    end
    if (exp_kind.size() != 0) begin
      k   = exp_kind.pop_front();
      idx = exp_idx.pop_front();
      d   = exp_data.pop_front();
      compare_field("kind", 32'(k), 32'(o_ret_kind));
      compare_field("idx", 32'(idx), 32'(o_ret_idx));
      compare_field("data", d, o_ret_data);
    end
    i_ret_ack = 1'b1;               // commit happens on this
    n = 0;
    while (o_ret_req && n < TMO) begin
      tick();
      n++;
    end
    if (o_ret_req) report_timeout("retire req stayed high after ack");
    i_ret_ack = 1'b0;
  endtask

  // retire monitor
  initial begin
    i_ret_ack = 1'b0;
    forever begin
      tick();
      if (o_ret_req && !hold_ret)
        take_retire();
    end
  end

`include "tb_tests.svh"

  initial begin
    seed       = 74;
    check_errs = 0;
    timeouts   = 0;
    cur_test   = "reset";
    hold_ret   = 1'b0;
    i_arst_n   = 1'b0;
    i_ins_req  = 1'b0;
    i_ins_word = '0;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++)
      model_mem[i] = '0;  // memory resets to zero
    repeat (16) tick();
    i_arst_n = 1'b1;
    tick();
    imm_alu_ops();
    rtype_ops();
    overflow_trap();
    memory_access();
    back_pressure();
    unsupported_opcode();
    $display("errors: %0d failed checks, %0d timeouts", check_errs, timeouts);
    if (check_errs == 0 && timeouts == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+tb
source/mips_pkg.sv
source/d_control.sv
source/alu.sv
source/reg_file.sv
source/decode_stage.sv
source/op_fifo.sv
source/exec_stage.sv
source/mips_exec_top.sv
tb/tb_mips_exec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mips_exec -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
